// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_width     = word_width * words_per_line;  // 128
    localparam int num_sets       = 16;
    localparam int num_ways       = 2;
    localparam int offset_bits    = 4;   // byte offset inside a line
    localparam int word_sel_bits  = 2;
    localparam int index_bits     = 4;
    localparam int tag_bits       = addr_width - index_bits - offset_bits;  // 24
    localparam int mask_width     = word_width / 8;  // one bit per byte

    typedef enum logic {
        op_read,
        op_write
    } bus_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_cache,
        st_read_cache,
        st_write_mem,
        st_read_mem,
        st_refill
    } cache_state_e;

    typedef enum logic [1:0] {
        tag_none,
        tag_read,
        tag_set_dirty,
        tag_fill
    } tag_cmd_e;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        logic [mask_width-1:0] byte_mask;
        bus_op_e               op;
    } cpu_req_t;

    typedef struct packed {
        logic                  done;
        logic [word_width-1:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;  // line aligned
        logic [line_width-1:0] line;
        bus_op_e               op;
    } mem_req_t;

    // tag compare result, held until the next tag_read
    typedef struct packed {
        logic                hit;
        logic                hit_way;
        logic                victim_way;
        logic                victim_dirty;
        logic [tag_bits-1:0] victim_tag;
    } lookup_t;

endpackage

// ==== logic/tag_lookup.sv ====
module tag_lookup (
    input  logic                              clock,
    input  logic                              reset_n,
    input  dcache_pkg::tag_cmd_e              tag_cmd,
    input  logic [dcache_pkg::index_bits-1:0] tag_index,
    input  logic [dcache_pkg::tag_bits-1:0]   tag_addr_tag,
    input  logic                              fill_way,
    input  logic                              fill_dirty,
    output dcache_pkg::lookup_t               lookup
);
    import dcache_pkg::*;

    logic [tag_bits-1:0] tags_q  [num_sets][num_ways];
    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    logic [num_sets-1:0] lru_q;  // per set, the way to evict next

    logic [num_ways-1:0] match;
    logic                victim_way;
    lookup_t             lookup_d;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid_q[tag_index][w] && (tags_q[tag_index][w] == tag_addr_tag);
        end

        // lowest free way first, then whatever lru names
        if (!valid_q[tag_index][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[tag_index][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[tag_index];
        end

        lookup_d.hit          = |match;
        lookup_d.hit_way      = match[1];
        lookup_d.victim_way   = victim_way;
        lookup_d.victim_dirty = valid_q[tag_index][victim_way] && dirty_q[tag_index][victim_way];
        lookup_d.victim_tag   = tags_q[tag_index][victim_way];
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q  <= '0;
            lookup <= '0;
        end else begin
            case (tag_cmd)
                tag_read: begin
                    lookup <= lookup_d;
                    if (lookup_d.hit) begin
                        lru_q[tag_index] <= ~lookup_d.hit_way;  // other way becomes lru
                    end
                end
                tag_set_dirty: begin
                    dirty_q[tag_index][lookup.hit_way] <= 1'b1;
                end
                tag_fill: begin
                    valid_q[tag_index][fill_way] <= 1'b1;
                    dirty_q[tag_index][fill_way] <= fill_dirty;
                    lru_q[tag_index]             <= ~fill_way;
                end
                default: begin
                    lookup <= lookup;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (tag_cmd == tag_fill) begin
            tags_q[tag_index][fill_way] <= tag_addr_tag;
        end
    end

endmodule

// ==== logic/data_store.sv ====
module data_store (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 rd_en,
    input  logic                                 wr_word_en,
    input  logic                                 wr_line_en,
    input  logic                                 way,
    input  logic [dcache_pkg::index_bits-1:0]    index,
    input  logic [dcache_pkg::word_sel_bits-1:0] word_sel,
    input  logic [dcache_pkg::word_width-1:0]    wdata,
    input  logic [dcache_pkg::mask_width-1:0]    byte_mask,
    input  logic [dcache_pkg::line_width-1:0]    wline,
    output logic [dcache_pkg::line_width-1:0]    rline
);
    import dcache_pkg::*;

    logic [line_width-1:0] lines_q [num_ways][num_sets];

    always_ff @(posedge clock) begin
        if (wr_line_en) begin
            lines_q[way][index] <= wline;  // refill replaces all words
        end else if (wr_word_en) begin
            for (int b = 0; b < mask_width; b++) begin
                if (byte_mask[b]) begin
                    lines_q[way][index][word_sel*word_width + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read data held until the next rd_en
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rline <= '0;
        end else if (rd_en) begin
            rline <= lines_q[way][index];
        end
    end

endmodule

// ==== logic/cache_ctrl.sv ====
module cache_ctrl (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 cpu_req_valid,
    input  dcache_pkg::cpu_req_t                 cpu_req,
    output logic                                 cpu_req_ready,
    output dcache_pkg::cpu_resp_t                cpu_resp,
    output logic                                 mem_req_valid,
    output dcache_pkg::mem_req_t                 mem_req,
    input  logic                                 mem_req_ready,
    input  logic                                 mem_done,
    input  logic [dcache_pkg::line_width-1:0]    mem_rdata,
    input  dcache_pkg::lookup_t                  lookup,
    output dcache_pkg::tag_cmd_e                 tag_cmd,
    output logic [dcache_pkg::index_bits-1:0]    tag_index,
    output logic [dcache_pkg::tag_bits-1:0]      tag_addr_tag,
    output logic                                 fill_way,
    output logic                                 fill_dirty,
    output logic                                 rd_en,
    output logic                                 wr_word_en,
    output logic                                 wr_line_en,
    output logic                                 way,
    output logic [dcache_pkg::index_bits-1:0]    index,
    output logic [dcache_pkg::word_sel_bits-1:0] word_sel,
    output logic [dcache_pkg::word_width-1:0]    wdata,
    output logic [dcache_pkg::mask_width-1:0]    byte_mask,
    output logic [dcache_pkg::line_width-1:0]    wline,
    input  logic [dcache_pkg::line_width-1:0]    rline
);
    import dcache_pkg::*;

    cache_state_e             state_q;
    cache_state_e             state_d;
    logic                     phase_q;        // second cycle of a registered read
    logic                     outstanding_q;  // memory op fired, done not seen yet
    cpu_req_t                 req_q;
    logic [line_width-1:0]    fill_line_q;

    logic [index_bits-1:0]    req_index;
    logic [tag_bits-1:0]      req_tag;
    logic [word_sel_bits-1:0] req_word;
    logic                     mem_fire;

    function automatic logic [word_width-1:0] pick_word(input logic [line_width-1:0] line,
                                                       input logic [word_sel_bits-1:0] sel);
        return line[sel*word_width +: word_width];
    endfunction

    // masked store bytes over the refilled line
    function automatic logic [line_width-1:0] merge_store(input logic [line_width-1:0] line,
                                                         input cpu_req_t req);
        logic [line_width-1:0]    merged;
        logic [word_sel_bits-1:0] sel;
        merged = line;
        sel    = req.addr[offset_bits-word_sel_bits +: word_sel_bits];
        for (int b = 0; b < mask_width; b++) begin
            if (req.byte_mask[b]) begin
                merged[sel*word_width + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_index = req_q.addr[offset_bits +: index_bits];
    assign req_tag   = req_q.addr[offset_bits+index_bits +: tag_bits];
    assign req_word  = req_q.addr[offset_bits-word_sel_bits +: word_sel_bits];
    assign mem_fire  = mem_req_valid && mem_req_ready;

    assign cpu_req_ready = (state_q == st_idle);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:        if (cpu_req_valid) state_d = st_lookup;
            st_lookup: begin
                if (phase_q) begin  // lookup is valid now
                    if (lookup.hit) begin
                        state_d = (req_q.op == op_write) ? st_write_cache : st_read_cache;
                    end else if (lookup.victim_dirty) begin
                        state_d = st_read_cache;  // fetch victim line first
                    end else begin
                        state_d = st_read_mem;
                    end
                end
            end
            st_write_cache: state_d = st_idle;
            st_read_cache: begin
                if (phase_q) begin
                    state_d = lookup.hit ? st_idle : st_write_mem;
                end
            end
            st_write_mem:   if (mem_done) state_d = st_read_mem;
            st_read_mem:    if (mem_done) state_d = st_refill;
            st_refill:      state_d = st_idle;
            default:        state_d = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q       <= st_idle;
            phase_q       <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            state_q <= state_d;
            phase_q <= (state_q == st_lookup || state_q == st_read_cache) && !phase_q;
            if (mem_fire) begin
                outstanding_q <= 1'b1;
            end else if (mem_done) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
        if (state_q == st_read_mem && mem_done) begin
            fill_line_q <= (req_q.op == op_write) ? merge_store(mem_rdata, req_q) : mem_rdata;
        end
    end

    // tag store and data store controls
    assign tag_cmd = (state_q == st_lookup && !phase_q) ? tag_read      :
                     (state_q == st_write_cache)         ? tag_set_dirty :
                     (state_q == st_refill)              ? tag_fill      : tag_none;
    assign tag_index    = req_index;
    assign tag_addr_tag = req_tag;
    assign fill_way     = lookup.victim_way;
    assign fill_dirty   = (req_q.op == op_write);

    assign rd_en      = (state_q == st_read_cache) && !phase_q;
    assign wr_word_en = (state_q == st_write_cache);
    assign wr_line_en = (state_q == st_refill);
    assign way        = lookup.hit ? lookup.hit_way : lookup.victim_way;
    assign index      = req_index;
    assign word_sel   = req_word;
    assign wdata      = req_q.wdata;
    assign byte_mask  = req_q.byte_mask;
    assign wline      = fill_line_q;

    // memory port, request held until it fires
    always_comb begin
        mem_req_valid = 1'b0;
        mem_req       = '0;
        mem_req.op    = op_read;
        if (state_q == st_write_mem) begin
            mem_req_valid = !outstanding_q;
            mem_req.addr  = {lookup.victim_tag, req_index, {offset_bits{1'b0}}};
            mem_req.line  = rline;
            mem_req.op    = op_write;
        end else if (state_q == st_read_mem) begin
            mem_req_valid = !outstanding_q;
            mem_req.addr  = {req_tag, req_index, {offset_bits{1'b0}}};
        end
    end

    always_comb begin
        cpu_resp = '0;
        case (state_q)
            st_write_cache: cpu_resp.done = 1'b1;
            st_read_cache: begin
                if (phase_q && lookup.hit) begin
                    cpu_resp.done  = 1'b1;
                    cpu_resp.rdata = pick_word(rline, req_word);
                end
            end
            st_refill: begin
                cpu_resp.done = 1'b1;
                if (req_q.op == op_read) begin
                    cpu_resp.rdata = pick_word(fill_line_q, req_word);
                end
            end
            default: cpu_resp = '0;
        endcase
    end

endmodule

// ==== logic/dcache_top.sv ====
module dcache_top (
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic                               cpu_req_valid,
    input  dcache_pkg::cpu_req_t               cpu_req,
    output logic                               cpu_req_ready,
    output dcache_pkg::cpu_resp_t              cpu_resp,
    output logic                               mem_req_valid,
    output dcache_pkg::mem_req_t               mem_req,
    input  logic                               mem_req_ready,
    input  logic                               mem_done,
    input  logic [dcache_pkg::line_width-1:0]  mem_rdata
);
    import dcache_pkg::*;

    tag_cmd_e                 tag_cmd;
    logic [index_bits-1:0]    tag_index;
    logic [tag_bits-1:0]      tag_addr_tag;
    logic                     fill_way;
    logic                     fill_dirty;
    lookup_t                  lookup;

    logic                     rd_en;
    logic                     wr_word_en;
    logic                     wr_line_en;
    logic                     way;
    logic [index_bits-1:0]    index;
    logic [word_sel_bits-1:0] word_sel;
    logic [word_width-1:0]    wdata;
    logic [mask_width-1:0]    byte_mask;
    logic [line_width-1:0]    wline;
    logic [line_width-1:0]    rline;

    tag_lookup u_tag_lookup (
        .clock        (clock),
        .reset_n      (reset_n),
        .tag_cmd      (tag_cmd),
        .tag_index    (tag_index),
        .tag_addr_tag (tag_addr_tag),
        .fill_way     (fill_way),
        .fill_dirty   (fill_dirty),
        .lookup       (lookup)
    );

    data_store u_data_store (
        .clock      (clock),
        .reset_n    (reset_n),
        .rd_en      (rd_en),
        .wr_word_en (wr_word_en),
        .wr_line_en (wr_line_en),
        .way        (way),
        .index      (index),
        .word_sel   (word_sel),
        .wdata      (wdata),
        .byte_mask  (byte_mask),
        .wline      (wline),
        .rline      (rline)
    );

    cache_ctrl u_cache_ctrl (
        .clock         (clock),
        .reset_n       (reset_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_resp      (cpu_resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .lookup        (lookup),
        .tag_cmd       (tag_cmd),
        .tag_index     (tag_index),
        .tag_addr_tag  (tag_addr_tag),
        .fill_way      (fill_way),
        .fill_dirty    (fill_dirty),
        .rd_en         (rd_en),
        .wr_word_en    (wr_word_en),
        .wr_line_en    (wr_line_en),
        .way           (way),
        .index         (index),
        .word_sel      (word_sel),
        .wdata         (wdata),
        .byte_mask     (byte_mask),
        .wline         (wline),
        .rline         (rline)
    );

endmodule

// ==== tests/dcache_bind_chk.sv ====
module dcache_bind_chk (
    input logic                 clock,
    input logic                 reset_n,
    input logic                 cpu_req_valid,
    input logic                 cpu_req_ready,
    input logic                 done,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input dcache_pkg::mem_req_t mem_req
);

    logic busy_q;  // between taking a request and its done
    int   fail_count = 0;  // failed assertion checks so far

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (cpu_req_valid && cpu_req_ready) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    mem_req_held: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request dropped or changed before it was accepted");
        end

    done_single: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for two cycles");
        end

    ready_low_busy: assert property (@(posedge clock) disable iff (!reset_n)
        busy_q |-> !cpu_req_ready)
        else begin
            fail_count++;
            $error("cpu_req_ready high while a request is in flight");
        end

endmodule

bind cache_ctrl dcache_bind_chk u_bind_chk (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_ready (cpu_req_ready),
    .done          (cpu_resp.done),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req)
);

// ==== tests/dcache_monitor.sv ====
module dcache_monitor (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              cpu_req_valid,
    input  logic                              cpu_req_ready,
    input  logic [dcache_pkg::addr_width-1:0] req_addr,
    input  dcache_pkg::cpu_resp_t             cpu_resp,
    input  logic [dcache_pkg::word_width-1:0] exp_rdata,
    output int                                data_errors,
    output int                                protocol_errors,
    output int                                responses
);
    import dcache_pkg::*;

    logic                  pending;  // request taken, response not seen yet
    logic [addr_width-1:0] addr_q;
    logic [word_width-1:0] exp_q;

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending         <= 1'b0;
            addr_q          <= '0;
            exp_q           <= '0;
            data_errors     <= 0;
            protocol_errors <= 0;
            responses       <= 0;
        end else begin
            if (cpu_resp.done) begin
                if (!pending) begin
                    protocol_errors <= protocol_errors + 1;
                    $display("done pulse at time %0t with no request outstanding", $time);
                end else begin
                    responses <= responses + 1;
                    if (cpu_resp.rdata !== exp_q) begin
                        data_errors <= data_errors + 1;
                        $display("ERR cpu_resp.rdata addr %h: expected %h, actual %h",
                                 addr_q, exp_q, cpu_resp.rdata);
                    end
                end
                pending <= 1'b0;
            end
            // ready is low while done is high, so no overlap here
            if (cpu_req_valid && cpu_req_ready) begin
                pending <= 1'b1;
                addr_q  <= req_addr;
                exp_q   <= exp_rdata;  // zero for stores
            end
        end
    end

endmodule

// ==== tests/tb_dcache.sv ====
module tb_dcache;
    import dcache_pkg::*;

    localparam int max_ops   = 64;
    localparam int op_fields = 5;  // op, addr, wdata, mask, expected rdata

    logic                  clock;
    logic                  reset_n;
    logic                  cpu_req_valid;
    cpu_req_t              cpu_req;
    logic                  cpu_req_ready;
    cpu_resp_t             cpu_resp;
    logic                  mem_req_valid;
    mem_req_t              mem_req;
    logic                  mem_req_ready;
    logic                  mem_done;
    logic [line_width-1:0] mem_rdata;
    logic [word_width-1:0] exp_rdata;

    logic [31:0] test_words [max_ops*op_fields];
    logic [31:0] mem_words [logic [31:0]];  // keyed by word byte address
    int          num_ops;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          data_errors;
    int          protocol_errors;
    int          assert_errors;
    int          responses;
    integer      seed        = 32'hdeac_acdf;

    dcache_top uut (
        .clock         (clock),
        .reset_n       (reset_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_resp      (cpu_resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata)
    );

    dcache_monitor u_monitor (
        .clock           (clock),
        .reset_n         (reset_n),
        .cpu_req_valid   (cpu_req_valid),
        .cpu_req_ready   (cpu_req_ready),
        .req_addr        (cpu_req.addr),
        .cpu_resp        (cpu_resp),
        .exp_rdata       (exp_rdata),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors),
        .responses       (responses)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // untouched words carry their own address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ 32'ha5a5_0000;
    endfunction

    task automatic complete_mem_op(input mem_req_t req);
        logic [31:0] word_addr;
        for (int w = 0; w < words_per_line; w++) begin
            word_addr = req.addr + 32'(4 * w);
            if (req.op == op_write) begin
                mem_words[word_addr] = req.line[w*word_width +: word_width];
            end else begin
                mem_rdata[w*word_width +: word_width] = read_word(word_addr);
            end
        end
    endtask

    task automatic run_op(input int n);
        logic [31:0] op_word;
        op_word = test_words[n*op_fields];
        @(posedge clock);
        #2;
        while (!cpu_req_ready) begin
            @(posedge clock);
            #2;
        end
        cpu_req.op        = (op_word == 0) ? op_read : op_write;
        cpu_req.addr      = test_words[n*op_fields + 1];
        cpu_req.wdata     = test_words[n*op_fields + 2];
        cpu_req.byte_mask = test_words[n*op_fields + 3][mask_width-1:0];
        exp_rdata         = test_words[n*op_fields + 4];
        cpu_req_valid     = 1'b1;
        @(posedge clock);  // taken here, ready was high
        #2;
        cpu_req_valid = 1'b0;
        while (!cpu_resp.done) begin
            @(negedge clock);
        end
    endtask

    // line memory with random accept stalls and 1 to 4 cycles to done
    initial begin : memory_model
        logic     fire;
        logic     busy;
        int       wait_cycles;
        mem_req_t held_req;
        mem_req_t active_req;
        mem_req_ready = 1'b0;
        mem_done      = 1'b0;
        mem_rdata     = '0;
        busy          = 1'b0;
        wait_cycles   = 0;
        forever begin
            @(negedge clock);
            fire     = mem_req_valid && mem_req_ready;
            held_req = mem_req;
            @(posedge clock);
            #2;
            mem_done = 1'b0;
            if (fire) begin
                busy          = 1'b1;
                active_req    = held_req;
                wait_cycles   = 1 + ($random(seed) & 3);
                mem_req_ready = 1'b0;
            end else if (busy) begin
                wait_cycles--;
                if (wait_cycles == 0) begin
                    complete_mem_op(active_req);
                    busy     = 1'b0;
                    mem_done = 1'b1;
                end
            end else begin
                mem_req_ready = (($random(seed) & 3) != 0);  // stall about one in four
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clock);
            cycles++;
            if (cycle_limit > 0 && cycles > cycle_limit) begin
                $display("timeout: run went past %0d cycles without finishing", cycle_limit);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    initial begin : stimulus
        reset_n       = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        exp_rdata     = '0;
        assert_errors = 0;
        for (int i = 0; i < max_ops*op_fields; i++) begin
            test_words[i] = '1;  // all ones marks the end of the list
        end
        $readmemh("tests/dcache_tests.txt", test_words);
        num_ops = 0;
        while (num_ops < max_ops && test_words[num_ops*op_fields] != '1) begin
            num_ops++;
        end
        cycle_limit = 60 * num_ops + 10;

        repeat (3) @(posedge clock);
        #2;
        reset_n = 1'b1;
        for (int n = 0; n < num_ops; n++) begin
            run_op(n);
        end
        repeat (3) @(negedge clock);  // let the monitor count the last response

        assert_errors = uut.u_cache_ctrl.u_bind_chk.fail_count;
        $display("errors: data %0d, protocol %0d, assertion %0d; responses %0d of %0d",
                 data_errors, protocol_errors, assert_errors, responses, num_ops);
        if (num_ops > 0 && data_errors == 0 && protocol_errors == 0 && assert_errors == 0 &&
            responses == num_ops) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/dcache_tests.txt ====
// columns: op (0 load, 1 store), byte address, store data, byte mask, expected rdata
// expected rdata is zero for stores; unwritten memory reads as address ^ a5a50000
0 00000104 00000000 0 a5a50104
0 00000104 00000000 0 a5a50104
0 0000010c 00000000 0 a5a5010c
1 00000108 11223344 5 00000000
0 00000108 00000000 0 a5220144
0 00000104 00000000 0 a5a50104
1 00000234 deadbeef c 00000000
0 00000234 00000000 0 dead0234
0 00000238 00000000 0 a5a50238
1 00000154 cafef00d f 00000000
1 00000258 0badc0de f 00000000
0 00000154 00000000 0 cafef00d
0 0000035c 00000000 0 a5a5035c
0 00000258 00000000 0 0badc0de
0 00000250 00000000 0 a5a50250
0 00000154 00000000 0 cafef00d
0 abcde000 00000000 0 0e68e000
0 12345600 00000000 0 b7915600
0 00000108 00000000 0 a5220144
1 00000108 ff00ff00 a 00000000
0 00000108 00000000 0 ff22ff44
1 00000104 000000aa 1 00000000
0 00000104 00000000 0 a5a501aa
0 12345604 00000000 0 b7915604

// ==== tb.f ====
logic/dcache_pkg.sv
logic/tag_lookup.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
tests/dcache_bind_chk.sv
tests/dcache_monitor.sv
tests/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
